// File: source/epcq_macros.svh
`ifndef EPCQ_MACROS_SVH
`define EPCQ_MACROS_SVH

// word address of the memory port
`define EPCQ_ADDR_WIDTH 22

// byte address of the flash, word address plus two byte bits
`define EPCQ_ASMI_ADDR_WIDTH 24

`define EPCQ_CSR_DATA_WIDTH 32

// burst count in words
`define EPCQ_BURST_WIDTH 7

// sector number and protect bits start here in csr write data
`define EPCQ_SECTOR_LSB 8

`endif

// File: source/epcq_pkg.sv
`include "epcq_macros.svh"

package epcq_pkg;

	// csr word offsets
	typedef enum logic [2:0] {
		CSR_STATUS = 3'd0,
		CSR_SID    = 3'd1,
		CSR_RDID   = 3'd2,
		CSR_MEM_OP = 3'd3,
		CSR_ISR    = 3'd4,
		CSR_IMR    = 3'd5
	} csr_addr_t;

	// operation field of a write to CSR_MEM_OP, data bits 1:0
	typedef enum logic [1:0] {
		OP_NONE           = 2'd0,
		OP_BULK_ERASE     = 2'd1,
		OP_SECTOR_ERASE   = 2'd2,
		OP_SECTOR_PROTECT = 2'd3
	} mem_op_t;

	// flash bytes in one burst, four per word
	typedef logic [`EPCQ_BURST_WIDTH+1:0] byte_count_t;

endpackage

// File: source/flash_cmd_if.sv
`timescale 1ns/1ps
`include "epcq_macros.svh"

interface flash_cmd_if;

	// requests from the csr block
	logic                             cmd_accepted;
	logic                             erase_addr_load;
	logic [`EPCQ_ASMI_ADDR_WIDTH-1:0] erase_addr;

	// requests from the burst reader
	logic                             read_accepted;
	logic [`EPCQ_ASMI_ADDR_WIDTH-1:0] read_addr;

	// arbiter state
	logic                             busy_fall;
	logic                             waitrequest;

	modport csr (output cmd_accepted, erase_addr_load, erase_addr, input waitrequest);

	modport reader (output read_accepted, read_addr, input waitrequest);

	modport arbiter (
		input  cmd_accepted, erase_addr_load, erase_addr, read_accepted, read_addr,
		output busy_fall, waitrequest
	);

endinterface

// File: source/access_arbiter.sv
`timescale 1ns/1ps
`include "epcq_macros.svh"

module access_arbiter (
	input  logic                             clk,
	input  logic                             reset_n,
	input  logic                             asmi_busy,
	flash_cmd_if.arbiter                     cmd,
	output logic [`EPCQ_ASMI_ADDR_WIDTH-1:0] asmi_addr,
	input  logic                             asmi_wren_in,
	output logic                             asmi_wren
);

	logic busy_reg;
	logic pending;

	// busy_reg covers the cycle right after the device drops busy
	assign cmd.busy_fall = busy_reg & ~asmi_busy;

	// one waitrequest serves both slave ports
	assign cmd.waitrequest = asmi_busy | busy_reg | pending;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			busy_reg <= 1'b0;
			pending  <= 1'b0;
		end else begin
			busy_reg <= asmi_busy;
			// held from the cycle after acceptance until busy has gone low
			if (cmd.cmd_accepted || cmd.read_accepted) begin
				pending <= 1'b1;
			end else if (cmd.busy_fall) begin
				pending <= 1'b0;
			end
		end
	end

	// flash byte address, valid together with the command strobe
	always_ff @(posedge clk) begin
		if (cmd.erase_addr_load) begin
			asmi_addr <= cmd.erase_addr;
		end else if (cmd.read_accepted) begin
			asmi_addr <= cmd.read_addr;
		end
	end

	// erase and protect write enable from the csr block
	assign asmi_wren = asmi_wren_in;

endmodule

// File: source/csr_regs.sv
`timescale 1ns/1ps
`include "epcq_macros.svh"

module csr_regs (
	input  logic                            clk,
	input  logic                            reset_n,
	input  logic                            avl_csr_write,
	input  logic                            avl_csr_read,
	input  logic [2:0]                      avl_csr_addr,
	input  logic [`EPCQ_CSR_DATA_WIDTH-1:0] avl_csr_wrdata,
	output logic [`EPCQ_CSR_DATA_WIDTH-1:0] avl_csr_rddata,
	output logic                            avl_csr_rddata_valid,
	input  logic                            asmi_busy,
	input  logic                            asmi_illegal_erase,
	input  logic                            asmi_illegal_write,
	input  logic [7:0]                      asmi_status_out,
	input  logic [7:0]                      asmi_epcs_id,
	input  logic [7:0]                      asmi_rdid_out,
	output logic                            asmi_read_status,
	output logic                            asmi_read_sid,
	output logic                            asmi_read_rdid,
	output logic                            asmi_bulk_erase,
	output logic                            asmi_sector_erase,
	output logic                            asmi_sector_protect,
	output logic [7:0]                      asmi_datain,
	output logic                            asmi_wren,
	output logic                            irq,
	flash_cmd_if.csr                        cmd
);
	import epcq_pkg::*;

	localparam int SEC = `EPCQ_SECTOR_LSB;

	csr_addr_t addr;
	mem_op_t   op;
	logic rd_acc, wr_acc;
	logic rd_status, rd_sid, rd_rdid, rd_isr, rd_imr, wr_isr, wr_imr;
	logic bulk_erase, sector_erase, sector_protect;
	logic status_en, sid_en, rdid_en;
	logic [1:0] isr, imr;
	logic reg_valid;
	logic [`EPCQ_CSR_DATA_WIDTH-1:0] reg_rdata;

	assign addr   = csr_addr_t'(avl_csr_addr);
	assign op     = mem_op_t'(avl_csr_wrdata[1:0]);
	assign rd_acc = avl_csr_read & ~cmd.waitrequest;
	assign wr_acc = avl_csr_write & ~cmd.waitrequest;

	always_comb begin
		rd_status      = 1'b0;
		rd_sid         = 1'b0;
		rd_rdid        = 1'b0;
		rd_isr         = 1'b0;
		rd_imr         = 1'b0;
		wr_isr         = 1'b0;
		wr_imr         = 1'b0;
		bulk_erase     = 1'b0;
		sector_erase   = 1'b0;
		sector_protect = 1'b0;
		case (addr)
			CSR_STATUS: rd_status = rd_acc;
			CSR_SID:    rd_sid = rd_acc;
			CSR_RDID:   rd_rdid = rd_acc;
			CSR_MEM_OP: begin
				if (wr_acc) begin
					case (op)
						OP_BULK_ERASE:     bulk_erase = 1'b1;
						OP_SECTOR_ERASE:   sector_erase = 1'b1;
						OP_SECTOR_PROTECT: sector_protect = 1'b1;
						// nothing sent to the device
						OP_NONE: ;
					endcase
				end
			end
			CSR_ISR: begin
				rd_isr = rd_acc;
				wr_isr = wr_acc;
			end
			CSR_IMR: begin
				rd_imr = rd_acc;
				wr_imr = wr_acc;
			end
			default: ;
		endcase
	end

	// isr and imr accesses are left out, they never wait on the device
	assign cmd.cmd_accepted = rd_status | rd_sid | rd_rdid |
		bulk_erase | sector_erase | sector_protect;
	assign cmd.erase_addr_load = sector_erase;
	// start address of the sector
	assign cmd.erase_addr = {avl_csr_wrdata[SEC+7:SEC], {(`EPCQ_ASMI_ADDR_WIDTH-8){1'b0}}};

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			asmi_read_status    <= 1'b0;
			asmi_read_sid       <= 1'b0;
			asmi_read_rdid      <= 1'b0;
			asmi_bulk_erase     <= 1'b0;
			asmi_sector_erase   <= 1'b0;
			asmi_sector_protect <= 1'b0;
			asmi_wren           <= 1'b0;
		end else begin
			asmi_read_status    <= rd_status;
			asmi_read_sid       <= rd_sid;
			asmi_read_rdid      <= rd_rdid;
			asmi_bulk_erase     <= bulk_erase;
			asmi_sector_erase   <= sector_erase;
			asmi_sector_protect <= sector_protect;
			asmi_wren           <= bulk_erase | sector_erase | sector_protect;
		end
	end

	// status register image: BP3 at bit 6, TB at bit 5, BP2..BP0 at bits 4..2
	always_ff @(posedge clk) begin
		if (sector_protect) begin
			asmi_datain <= {1'b0, avl_csr_wrdata[SEC+3], avl_csr_wrdata[SEC+4],
				avl_csr_wrdata[SEC+2:SEC], 2'b00};
		end
	end

	// a device read waits here until busy is low again
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			status_en <= 1'b0;
			sid_en    <= 1'b0;
			rdid_en   <= 1'b0;
		end else begin
			if (asmi_read_status) begin
				status_en <= 1'b1;
			end else if (!asmi_busy) begin
				status_en <= 1'b0;
			end
			if (asmi_read_sid) begin
				sid_en <= 1'b1;
			end else if (!asmi_busy) begin
				sid_en <= 1'b0;
			end
			if (asmi_read_rdid) begin
				rdid_en <= 1'b1;
			end else if (!asmi_busy) begin
				rdid_en <= 1'b0;
			end
		end
	end

	// bit 1 illegal write, bit 0 illegal erase; a new flag wins over the clear
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			isr       <= 2'b00;
			imr       <= 2'b00;
			reg_valid <= 1'b0;
		end else begin
			isr[0]    <= asmi_illegal_erase | (isr[0] & ~(wr_isr & avl_csr_wrdata[0]));
			isr[1]    <= asmi_illegal_write | (isr[1] & ~(wr_isr & avl_csr_wrdata[1]));
			if (wr_imr) begin
				imr <= avl_csr_wrdata[1:0];
			end
			reg_valid <= rd_isr | rd_imr;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_isr) begin
			reg_rdata <= {{(`EPCQ_CSR_DATA_WIDTH-2){1'b0}}, isr};
		end else if (rd_imr) begin
			reg_rdata <= {{(`EPCQ_CSR_DATA_WIDTH-2){1'b0}}, imr};
		end
	end

	always_comb begin
		if (status_en) begin
			avl_csr_rddata = {{(`EPCQ_CSR_DATA_WIDTH-8){1'b0}}, asmi_status_out};
		end else if (sid_en) begin
			avl_csr_rddata = {{(`EPCQ_CSR_DATA_WIDTH-8){1'b0}}, asmi_epcs_id};
		end else if (rdid_en) begin
			avl_csr_rddata = {{(`EPCQ_CSR_DATA_WIDTH-8){1'b0}}, asmi_rdid_out};
		end else begin
			avl_csr_rddata = reg_rdata;
		end
	end

	assign avl_csr_rddata_valid = ((status_en | sid_en | rdid_en) & ~asmi_busy) | reg_valid;

	assign irq = |(isr & imr);

endmodule

// File: source/mem_burst_reader.sv
`timescale 1ns/1ps
`include "epcq_macros.svh"

module mem_burst_reader (
	input  logic                         clk,
	input  logic                         reset_n,
	input  logic                         avl_mem_read,
	input  logic [`EPCQ_ADDR_WIDTH-1:0]  avl_mem_addr,
	input  logic [`EPCQ_BURST_WIDTH-1:0] avl_mem_burstcount,
	input  logic                         asmi_data_valid,
	input  logic [7:0]                   asmi_dataout,
	output logic [31:0]                  avl_mem_rddata,
	output logic                         avl_mem_rddata_valid,
	output logic                         asmi_rden,
	output logic                         asmi_fast_read,
	flash_cmd_if.reader                  cmd
);
	import epcq_pkg::*;

	logic        accept;
	byte_count_t byte_cnt;
	byte_count_t byte_total;
	logic [1:0]  lane;
	logic [3:0][7:0] lanes;

	assign accept = avl_mem_read & ~cmd.waitrequest;

	assign cmd.read_accepted = accept;
	// word address to flash byte address
	assign cmd.read_addr = {avl_mem_addr, 2'b00};

	// byte count of the burst, held for the end compare
	always_ff @(posedge clk) begin
		if (accept) begin
			byte_total <= {avl_mem_burstcount, 2'b00};
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			byte_cnt             <= '0;
			lane                 <= 2'd0;
			asmi_fast_read       <= 1'b0;
			avl_mem_rddata_valid <= 1'b0;
		end else begin
			asmi_fast_read <= accept;
			if (accept) begin
				byte_cnt <= 9'd1;
			end else if (byte_cnt == byte_total) begin
				byte_cnt <= '0;
			end else if (asmi_data_valid && byte_cnt != '0) begin
				byte_cnt <= byte_cnt + 9'd1;
			end
			// lanes fill 0..3 in order, a new burst starts again at lane 0
			if (accept) begin
				lane <= 2'd0;
			end else if (asmi_data_valid) begin
				lane <= lane + 2'd1;
			end
			avl_mem_rddata_valid <= asmi_data_valid & (lane == 2'd3) & ~accept;
		end
	end

	always_ff @(posedge clk) begin
		if (asmi_data_valid) begin
			lanes[lane] <= asmi_dataout;
		end
	end

	// rden drops once the final byte count is reached
	assign asmi_rden = (byte_cnt != '0);

	// first flash byte lands in the low byte
	assign avl_mem_rddata = lanes;

endmodule

// File: source/epcq_controller.sv
`timescale 1ns/1ps
`include "epcq_macros.svh"

module epcq_controller (
	input  logic                             clk,
	input  logic                             reset_n,
	// csr slave
	input  logic                             avl_csr_write,
	input  logic                             avl_csr_read,
	input  logic [2:0]                       avl_csr_addr,
	input  logic [`EPCQ_CSR_DATA_WIDTH-1:0]  avl_csr_wrdata,
	output logic [`EPCQ_CSR_DATA_WIDTH-1:0]  avl_csr_rddata,
	output logic                             avl_csr_rddata_valid,
	output logic                             avl_csr_waitrequest,
	// memory slave, burst reads only
	input  logic                             avl_mem_read,
	input  logic [`EPCQ_ADDR_WIDTH-1:0]      avl_mem_addr,
	input  logic [`EPCQ_BURST_WIDTH-1:0]     avl_mem_burstcount,
	output logic [31:0]                      avl_mem_rddata,
	output logic                             avl_mem_rddata_valid,
	output logic                             avl_mem_waitrequest,
	output logic                             irq,
	// asmi parallel port
	input  logic                             asmi_busy,
	input  logic                             asmi_data_valid,
	input  logic [7:0]                       asmi_dataout,
	input  logic                             asmi_illegal_erase,
	input  logic                             asmi_illegal_write,
	input  logic [7:0]                       asmi_status_out,
	input  logic [7:0]                       asmi_epcs_id,
	input  logic [7:0]                       asmi_rdid_out,
	output logic                             asmi_clkin,
	output logic                             asmi_reset,
	output logic [`EPCQ_ASMI_ADDR_WIDTH-1:0] asmi_addr,
	output logic [7:0]                       asmi_datain,
	output logic                             asmi_fast_read,
	output logic                             asmi_rden,
	output logic                             asmi_wren,
	output logic                             asmi_read_status,
	output logic                             asmi_read_sid,
	output logic                             asmi_read_rdid,
	output logic                             asmi_bulk_erase,
	output logic                             asmi_sector_erase,
	output logic                             asmi_sector_protect
);

	logic csr_wren;

	flash_cmd_if cmd_bus ();

	assign asmi_clkin = clk;
	assign asmi_reset = ~reset_n;

	// both ports stall together while the device is in use
	assign avl_csr_waitrequest = cmd_bus.waitrequest;
	assign avl_mem_waitrequest = cmd_bus.waitrequest;

	access_arbiter u_arbiter (
		.clk          (clk),
		.reset_n      (reset_n),
		.asmi_busy    (asmi_busy),
		.cmd          (cmd_bus.arbiter),
		.asmi_addr    (asmi_addr),
		.asmi_wren_in (csr_wren),
		.asmi_wren    (asmi_wren)
	);

	csr_regs u_csr (
		.clk                  (clk),
		.reset_n              (reset_n),
		.avl_csr_write        (avl_csr_write),
		.avl_csr_read         (avl_csr_read),
		.avl_csr_addr         (avl_csr_addr),
		.avl_csr_wrdata       (avl_csr_wrdata),
		.avl_csr_rddata       (avl_csr_rddata),
		.avl_csr_rddata_valid (avl_csr_rddata_valid),
		.asmi_busy            (asmi_busy),
		.asmi_illegal_erase   (asmi_illegal_erase),
		.asmi_illegal_write   (asmi_illegal_write),
		.asmi_status_out      (asmi_status_out),
		.asmi_epcs_id         (asmi_epcs_id),
		.asmi_rdid_out        (asmi_rdid_out),
		.asmi_read_status     (asmi_read_status),
		.asmi_read_sid        (asmi_read_sid),
		.asmi_read_rdid       (asmi_read_rdid),
		.asmi_bulk_erase      (asmi_bulk_erase),
		.asmi_sector_erase    (asmi_sector_erase),
		.asmi_sector_protect  (asmi_sector_protect),
		.asmi_datain          (asmi_datain),
		.asmi_wren            (csr_wren),
		.irq                  (irq),
		.cmd                  (cmd_bus.csr)
	);

	mem_burst_reader u_reader (
		.clk                  (clk),
		.reset_n              (reset_n),
		.avl_mem_read         (avl_mem_read),
		.avl_mem_addr         (avl_mem_addr),
		.avl_mem_burstcount   (avl_mem_burstcount),
		.asmi_data_valid      (asmi_data_valid),
		.asmi_dataout         (asmi_dataout),
		.avl_mem_rddata       (avl_mem_rddata),
		.avl_mem_rddata_valid (avl_mem_rddata_valid),
		.asmi_rden            (asmi_rden),
		.asmi_fast_read       (asmi_fast_read),
		.cmd                  (cmd_bus.reader)
	);

endmodule

// File: tb/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
	output logic clk,
	output logic reset_n
);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// low over four rising edges, released on a falling edge
	initial begin
		reset_n = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
	end

endmodule

// File: tb/asmi_flash_model.sv
`timescale 1ns/1ps
`include "epcq_macros.svh"

module asmi_flash_model (
	input  logic                             clk,
	input  logic                             reset_n,
	input  logic                             asmi_read_status,
	input  logic                             asmi_read_sid,
	input  logic                             asmi_read_rdid,
	input  logic                             asmi_bulk_erase,
	input  logic                             asmi_sector_erase,
	input  logic                             asmi_sector_protect,
	input  logic                             asmi_fast_read,
	input  logic                             asmi_rden,
	input  logic [`EPCQ_ASMI_ADDR_WIDTH-1:0] asmi_addr,
	input  logic [`EPCQ_BURST_WIDTH-1:0]     burst_words,
	output logic                             asmi_busy,
	output logic                             asmi_data_valid,
	output logic [7:0]                       asmi_dataout,
	output logic [7:0]                       asmi_status_out,
	output logic [7:0]                       asmi_epcs_id,
	output logic [7:0]                       asmi_rdid_out
);

	logic                             start;
	logic [2:0]                       busy_cnt;
	logic [`EPCQ_ASMI_ADDR_WIDTH-1:0] next_addr;
	logic [`EPCQ_BURST_WIDTH+1:0]     bytes_left;

	assign asmi_status_out = 8'h03;
	assign asmi_epcs_id    = 8'h18;
	assign asmi_rdid_out   = 8'h20;

	assign start = asmi_read_status | asmi_read_sid | asmi_read_rdid | asmi_bulk_erase |
		asmi_sector_erase | asmi_sector_protect | asmi_fast_read;

	// busy for six cycles, starting the cycle after any command
	assign asmi_busy = (busy_cnt != 3'd0);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			busy_cnt        <= 3'd0;
			asmi_data_valid <= 1'b0;
			asmi_dataout    <= 8'h00;
			next_addr       <= '0;
			bytes_left      <= '0;
		end else begin
			if (start) begin
				busy_cnt <= 3'd6;
			end else if (busy_cnt != 3'd0) begin
				busy_cnt <= busy_cnt - 3'd1;
			end
			// one byte per cycle, the value is its address xor 0x5a
			if (asmi_fast_read) begin
				asmi_data_valid <= 1'b1;
				asmi_dataout    <= asmi_addr[7:0] ^ 8'h5a;
				next_addr       <= asmi_addr + 24'd1;
				bytes_left      <= {burst_words, 2'b00} - 9'd1;
			end else if (asmi_rden && bytes_left != '0) begin
				asmi_data_valid <= 1'b1;
				asmi_dataout    <= next_addr[7:0] ^ 8'h5a;
				next_addr       <= next_addr + 24'd1;
				bytes_left      <= bytes_left - 9'd1;
			end else begin
				asmi_data_valid <= 1'b0;
			end
		end
	end

endmodule

// File: tb/epcq_properties.sv
`timescale 1ns/1ps

module epcq_properties (
	input logic clk,
	input logic reset_n,
	input logic asmi_busy,
	input logic avl_csr_waitrequest,
	input logic avl_mem_waitrequest,
	input logic asmi_read_status,
	input logic asmi_read_sid,
	input logic asmi_read_rdid,
	input logic asmi_bulk_erase,
	input logic asmi_sector_erase,
	input logic asmi_sector_protect,
	input logic asmi_fast_read,
	input logic asmi_rden,
	input logic avl_mem_rddata_valid
);

	logic [6:0] strobes;

	assign strobes = {asmi_read_status, asmi_read_sid, asmi_read_rdid, asmi_bulk_erase,
		asmi_sector_erase, asmi_sector_protect, asmi_fast_read};

	// a busy device or a command still on its way stalls both slave ports
	busy_stalls_ports: assert property (@(posedge clk) disable iff (!reset_n)
		(asmi_busy || strobes != 7'd0) |-> (avl_csr_waitrequest && avl_mem_waitrequest))
		else $error("waitrequest is low while a command is in flight or asmi_busy is high");

	strobe_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
		(strobes != 7'd0) |=> (strobes == 7'd0))
		else $error("a command strobe stayed high for more than one cycle");

	// the last word may follow rden by one cycle but no more
	valid_near_rden: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(avl_mem_rddata_valid) |-> (asmi_rden || $past(asmi_rden)))
		else $error("avl_mem_rddata_valid rose long after asmi_rden fell");

endmodule

bind epcq_controller epcq_properties u_props (
	.clk                  (clk),
	.reset_n              (reset_n),
	.asmi_busy            (asmi_busy),
	.avl_csr_waitrequest  (avl_csr_waitrequest),
	.avl_mem_waitrequest  (avl_mem_waitrequest),
	.asmi_read_status     (asmi_read_status),
	.asmi_read_sid        (asmi_read_sid),
	.asmi_read_rdid       (asmi_read_rdid),
	.asmi_bulk_erase      (asmi_bulk_erase),
	.asmi_sector_erase    (asmi_sector_erase),
	.asmi_sector_protect  (asmi_sector_protect),
	.asmi_fast_read       (asmi_fast_read),
	.asmi_rden            (asmi_rden),
	.avl_mem_rddata_valid (avl_mem_rddata_valid)
);

// File: tb/epcq_tb.sv
`timescale 1ns/1ps
`include "epcq_macros.svh"

module epcq_tb;
	import epcq_pkg::*;

	logic                             clk;
	logic                             reset_n;
	logic                             avl_csr_write;
	logic                             avl_csr_read;
	logic [2:0]                       avl_csr_addr;
	logic [`EPCQ_CSR_DATA_WIDTH-1:0]  avl_csr_wrdata;
	logic [`EPCQ_CSR_DATA_WIDTH-1:0]  avl_csr_rddata;
	logic                             avl_csr_rddata_valid;
	logic                             avl_csr_waitrequest;
	logic                             avl_mem_read;
	logic [`EPCQ_ADDR_WIDTH-1:0]      avl_mem_addr;
	logic [`EPCQ_BURST_WIDTH-1:0]     avl_mem_burstcount;
	logic [31:0]                      avl_mem_rddata;
	logic                             avl_mem_rddata_valid;
	logic                             avl_mem_waitrequest;
	logic                             irq;
	logic                             asmi_busy;
	logic                             asmi_data_valid;
	logic [7:0]                       asmi_dataout;
	logic                             asmi_illegal_erase;
	logic                             asmi_illegal_write;
	logic [7:0]                       asmi_status_out;
	logic [7:0]                       asmi_epcs_id;
	logic [7:0]                       asmi_rdid_out;
	logic                             asmi_clkin;
	logic                             asmi_reset;
	logic [`EPCQ_ASMI_ADDR_WIDTH-1:0] asmi_addr;
	logic [7:0]                       asmi_datain;
	logic                             asmi_fast_read;
	logic                             asmi_rden;
	logic                             asmi_wren;
	logic                             asmi_read_status;
	logic                             asmi_read_sid;
	logic                             asmi_read_rdid;
	logic                             asmi_bulk_erase;
	logic                             asmi_sector_erase;
	logic                             asmi_sector_protect;

	// one entry per stimulus line and the expected words of all lines in one queue
	string       names[$];
	string       ops[$];
	logic [31:0] addrs[$];
	logic [31:0] datas[$];
	int          exp_first[$];
	logic [31:0] exp_words[$];
	int          cycle_limit = 16;
	int          cycles = 0;
	int          checks_run = 0;

	clock_gen u_clock (.clk(clk), .reset_n(reset_n));

	asmi_flash_model u_flash (.burst_words(avl_mem_burstcount), .*);

	epcq_controller dut (.*);

	task automatic stop_on_failure(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		checks_run++;
		assert (actual === expected) else begin
			stop_on_failure($sformatf("MISMATCH %s expected 0x%08h actual 0x%08h",
				test, expected, actual));
		end
	endtask

	// waitrequest only changes on a rising edge and is stable here
	task automatic wait_until_accepted(input logic mem_port);
		while (mem_port ? avl_mem_waitrequest : avl_csr_waitrequest) begin
			@(negedge clk);
		end
		@(negedge clk);
	endtask

	task automatic write_csr(input string test, input logic [31:0] addr,
		input logic [31:0] data, input logic [31:0] expected);
		logic [6:0] want;
		logic [6:0] seen;
		avl_csr_write  = 1'b1;
		avl_csr_addr   = addr[2:0];
		avl_csr_wrdata = data;
		wait_until_accepted(1'b0);
		avl_csr_write = 1'b0;
		// status, sid, rdid, bulk, sector erase, protect, wren
		want = 7'd0;
		if (addr[2:0] == CSR_MEM_OP) begin
			case (mem_op_t'(data[1:0]))
				OP_BULK_ERASE:     want = 7'b0001001;
				OP_SECTOR_ERASE:   want = 7'b0000101;
				OP_SECTOR_PROTECT: want = 7'b0000011;
				default:           want = 7'd0;
			endcase
		end
		seen = {asmi_read_status, asmi_read_sid, asmi_read_rdid, asmi_bulk_erase,
			asmi_sector_erase, asmi_sector_protect, asmi_wren};
		check_value({test, " strobes"}, {25'd0, want}, {25'd0, seen});
		if (want == 7'b0000101) begin
			check_value({test, " asmi_addr"}, expected, {8'd0, asmi_addr});
		end else if (want == 7'b0000011) begin
			check_value({test, " asmi_datain"}, expected, {24'd0, asmi_datain});
		end
	endtask

	task automatic read_csr(input string test, input logic [31:0] addr,
		input logic [31:0] expected);
		logic [2:0] want;
		avl_csr_read = 1'b1;
		avl_csr_addr = addr[2:0];
		wait_until_accepted(1'b0);
		avl_csr_read = 1'b0;
		// status, sid, rdid
		case (addr[2:0])
			CSR_STATUS: want = 3'b100;
			CSR_SID:    want = 3'b010;
			CSR_RDID:   want = 3'b001;
			default:    want = 3'b000;
		endcase
		check_value({test, " strobes"}, {29'd0, want},
			{29'd0, asmi_read_status, asmi_read_sid, asmi_read_rdid});
		// isr and imr answer in the cycle after acceptance
		if (addr[2:0] == CSR_ISR || addr[2:0] == CSR_IMR) begin
			check_value({test, " valid"}, 32'd1, {31'd0, avl_csr_rddata_valid});
		end
		while (!avl_csr_rddata_valid) begin
			@(negedge clk);
		end
		check_value(test, expected, avl_csr_rddata);
	endtask

	task automatic read_burst(input string test, input logic [31:0] addr,
		input int count, input int first);
		int w;
		avl_mem_read       = 1'b1;
		avl_mem_addr       = addr[`EPCQ_ADDR_WIDTH-1:0];
		avl_mem_burstcount = count[`EPCQ_BURST_WIDTH-1:0];
		wait_until_accepted(1'b1);
		avl_mem_read = 1'b0;
		// four flash bytes per word
		check_value({test, " asmi_fast_read"}, 32'd1, {31'd0, asmi_fast_read});
		check_value({test, " asmi_addr"}, addr * 32'd4, {8'd0, asmi_addr});
		for (w = 0; w < count; w++) begin
			while (!avl_mem_rddata_valid) begin
				@(negedge clk);
			end
			check_value($sformatf("%s word %0d", test, w), exp_words[first + w], avl_mem_rddata);
			@(negedge clk);
		end
	endtask

	task automatic pulse_flag(input logic erase);
		asmi_illegal_erase = erase;
		asmi_illegal_write = !erase;
		@(negedge clk);
		asmi_illegal_erase = 1'b0;
		asmi_illegal_write = 1'b0;
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			stop_on_failure("timeout: the DUT did not finish within the cycle limit");
		end
	end

	initial begin
		int          fd;
		int          code;
		int          i;
		int          n_exp;
		string       tok;
		string       op;
		string       rest;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] w;
		avl_csr_write      = 1'b0;
		avl_csr_read       = 1'b0;
		avl_csr_addr       = 3'd0;
		avl_csr_wrdata     = '0;
		avl_mem_read       = 1'b0;
		avl_mem_addr       = '0;
		avl_mem_burstcount = '0;
		asmi_illegal_erase = 1'b0;
		asmi_illegal_write = 1'b0;

		fd = $fopen("tb/epcq_stimulus.txt", "r");
		if (fd == 0) begin
			stop_on_failure("cannot open tb/epcq_stimulus.txt");
		end
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok.substr(0, 0) == "#") begin
				code = $fgets(rest, fd);
			end else begin
				code = $fscanf(fd, "%s %h %h", op, a, d);
				if (code != 3) begin
					stop_on_failure({"incomplete stimulus line ", tok});
				end
				// a burst line lists one expected word per burst word
				n_exp = (op == "M") ? int'(d) : 1;
				names.push_back(tok);
				ops.push_back(op);
				addrs.push_back(a);
				datas.push_back(d);
				exp_first.push_back(exp_words.size());
				for (i = 0; i < n_exp; i++) begin
					code = $fscanf(fd, "%h", w);
					if (code != 1) begin
						stop_on_failure({"missing expected value in stimulus line ", tok});
					end
					exp_words.push_back(w);
				end
				cycle_limit = cycle_limit + 64 + ((op == "M") ? 16 * n_exp : 0);
			end
		end
		$fclose(fd);

		@(negedge clk);
		check_value("asmi_reset during reset", 32'd1, {31'd0, asmi_reset});
		wait (reset_n === 1'b1);
		@(negedge clk);
		// everything idle once reset is released
		check_value("idle after reset", 32'd0, {19'd0, asmi_read_status, asmi_read_sid,
			asmi_read_rdid, asmi_bulk_erase, asmi_sector_erase, asmi_sector_protect,
			asmi_wren, asmi_fast_read, avl_csr_rddata_valid, avl_mem_rddata_valid,
			avl_csr_waitrequest, avl_mem_waitrequest, irq});
		check_value("asmi_reset after reset", 32'd0, {31'd0, asmi_reset});
		// clk is settled low one ns after the falling edge
		#1;
		check_value("asmi_clkin", {31'd0, clk}, {31'd0, asmi_clkin});
		@(negedge clk);
		for (i = 0; i < names.size(); i++) begin
			if (ops[i] == "W") begin
				write_csr(names[i], addrs[i], datas[i], exp_words[exp_first[i]]);
			end else if (ops[i] == "R") begin
				read_csr(names[i], addrs[i], exp_words[exp_first[i]]);
			end else if (ops[i] == "M") begin
				read_burst(names[i], addrs[i], int'(datas[i]), exp_first[i]);
			end else if (ops[i] == "E") begin
				pulse_flag(1'b1);
			end else if (ops[i] == "V") begin
				pulse_flag(1'b0);
			end else if (ops[i] == "Q") begin
				check_value(names[i], exp_words[exp_first[i]], {31'd0, irq});
			end else begin
				stop_on_failure({"unknown opcode ", ops[i], " in stimulus line ", names[i]});
			end
		end

		@(negedge clk);
		if (checks_run > 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			stop_on_failure("the stimulus file held no checks");
		end
	end

endmodule

// File: tb/epcq_stimulus.txt
# columns: name opcode address data expected (hex), M lists one expected word per burst word
# opcodes: W csr write, R csr read, M burst read, E/V illegal erase/write pulse, Q irq level
rd_status R 0 0 03
rd_sid R 1 0 18
rd_rdid R 2 0 20
imr_clear W 5 0 0
sector_erase W 3 1202 120000
sector_protect W 3 1d03 74
bulk_erase W 3 1 0
rd_status_again R 0 0 03
erase_flag E 0 0 0
isr_erase_set R 4 0 1
isr_erase_clear W 4 1 0
isr_erase_gone R 4 0 0
imr_write W 5 2 0
imr_readback R 5 0 2
erase_masked E 0 0 0
irq_stays_low Q 0 0 0
write_flag V 0 0 0
irq_raised Q 0 0 1
isr_both_set R 4 0 3
isr_clear_all W 4 3 0
irq_cleared Q 0 0 0
burst_three M 40 3 59585b5a 5d5c5f5e 51505352
burst_single M 41 1 5d5c5f5e

// File: compile.f
+incdir+source
source/epcq_pkg.sv
source/flash_cmd_if.sv
source/access_arbiter.sv
source/csr_regs.sv
source/mem_burst_reader.sv
source/epcq_controller.sv
tb/clock_gen.sv
tb/asmi_flash_model.sv
tb/epcq_properties.sv
tb/epcq_tb.sv

// File: run.sh
#!/bin/sh
# build and run the epcq testbench with verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module epcq_tb -o epcq_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/epcq_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0
